// File: design/apu_regs_pkg.sv
package apu_regs_pkg;

	// CPU side register data
	localparam int REG_DATA_W = 8;

	typedef logic [REG_DATA_W-1:0] reg_data_t;

	// Frame register write layout
	localparam int FRAME_MODE_BIT    = 7;	// Set for the 5-step sequence
	localparam int FRAME_INHIBIT_BIT = 6;	// Set to block the frame interrupt

endpackage

// File: design/frame_timer_pkg.sv
package frame_timer_pkg;

	localparam int LFSR_W = 15;

	typedef logic [LFSR_W-1:0] lfsr_t;

	localparam lfsr_t LFSR_SEED = '1;	// Reload value

	// Aclk strobes counted from the last reload
	localparam int unsigned STEP1_COUNT = 3728;
	localparam int unsigned STEP2_COUNT = 7456;
	localparam int unsigned STEP3_COUNT = 11185;
	localparam int unsigned STEP4_COUNT = 14914;
	localparam int unsigned STEP5_COUNT = 18640;

	// New bit 0 from the two top taps
	function automatic logic lfsr_feedback(input lfsr_t s);
		return s[13] ^ s[14];
	endfunction

	// Shift toward the high bit
	function automatic lfsr_t lfsr_next(input lfsr_t s);
		return {s[LFSR_W-2:0], lfsr_feedback(s)};
	endfunction

	// Register value after a number of steps from the seed
	function automatic lfsr_t lfsr_pattern(input int unsigned count);
		lfsr_t s;
		s = LFSR_SEED;
		for (int unsigned blk = 0; blk <= count / 256; blk++) begin
			for (int unsigned i = 0; i < 256; i++) begin
				if (blk * 256 + i < count)
					s = lfsr_next(s);
			end
		end
		return s;
	endfunction

	localparam lfsr_t STEP1_PATTERN = lfsr_pattern(STEP1_COUNT);
	localparam lfsr_t STEP2_PATTERN = lfsr_pattern(STEP2_COUNT);
	localparam lfsr_t STEP3_PATTERN = lfsr_pattern(STEP3_COUNT);
	localparam lfsr_t STEP4_PATTERN = lfsr_pattern(STEP4_COUNT);
	localparam lfsr_t STEP5_PATTERN = lfsr_pattern(STEP5_COUNT);

	typedef logic [4:0] step_hits_t;	// Bit 0 is step 1

	typedef enum logic {
		SEQ_RUN,
		SEQ_RELOAD_PENDING
	} seq_state_e;

endpackage

// File: design/frame_sequencer_ctrl.sv
module frame_sequencer_ctrl (
	input  logic                       phi1,
	input  logic                       reset,
	input  apu_regs_pkg::reg_data_t    reg_data,
	input  logic                       write_frame,
	input  frame_timer_pkg::step_hits_t step_hits,
	input  frame_timer_pkg::lfsr_t     lfsr_state,
	output logic                       lfsr_reload,
	output logic                       lfsr_step,
	output logic                       feedback_in,
	output logic                       mode_5step,
	output logic                       irq_inhibit,
	output logic                       frame_irq_set,
	output logic                       quarter_frame,
	output logic                       half_frame
);

	import apu_regs_pkg::*;
	import frame_timer_pkg::*;

	logic       aclk_en;
	seq_state_e seq_state;
	logic       write_pending;
	logic       frame_end;
	logic       reload_now;
	logic       quarter_hit;
	logic       half_hit;

	// Audio clock as every second phi1 cycle
	always_ff @(posedge phi1) begin
		if (reset)
			aclk_en <= 1'b0;
		else
			aclk_en <= ~aclk_en;
	end

	// Frame register bits
	always_ff @(posedge phi1) begin
		if (reset) begin
			mode_5step  <= 1'b0;
			irq_inhibit <= 1'b0;
		end else if (write_frame) begin
			mode_5step  <= reg_data[FRAME_MODE_BIT];
			irq_inhibit <= reg_data[FRAME_INHIBIT_BIT];
		end
	end

	// A write restarts the sequence on the next strobe
	always_ff @(posedge phi1) begin
		if (reset)
			seq_state <= SEQ_RELOAD_PENDING;	// First strobe reloads
		else if (write_frame)
			seq_state <= SEQ_RELOAD_PENDING;
		else if (aclk_en)
			seq_state <= SEQ_RUN;
	end

	assign write_pending = (seq_state == SEQ_RELOAD_PENDING);

	// The decoder drops step 4 in 5-step mode
	assign frame_end  = step_hits[3] | step_hits[4];
	assign reload_now = write_pending | frame_end;

	assign lfsr_reload = aclk_en & reload_now;
	assign lfsr_step   = aclk_en & ~reload_now;
	assign feedback_in = lfsr_feedback(lfsr_state);

	// 5-step write fires an immediate quarter and half
	assign quarter_hit = (|step_hits) | (write_pending & mode_5step);
	assign half_hit    = step_hits[1] | step_hits[3] | step_hits[4] |
		(write_pending & mode_5step);

	always_ff @(posedge phi1) begin
		if (reset) begin
			quarter_frame <= 1'b0;
			half_frame    <= 1'b0;
			frame_irq_set <= 1'b0;
		end else begin
			quarter_frame <= aclk_en & quarter_hit;
			half_frame    <= aclk_en & half_hit;
			frame_irq_set <= aclk_en & step_hits[3];
		end
	end

endmodule

// File: design/frame_lfsr.sv
module frame_lfsr (
	input  logic                   phi1,
	input  logic                   reset,
	input  logic                   lfsr_reload,
	input  logic                   lfsr_step,
	input  logic                   feedback_in,
	output frame_timer_pkg::lfsr_t lfsr_state
);

	import frame_timer_pkg::*;

	lfsr_t shift_q;

	always_ff @(posedge phi1) begin
		if (reset || lfsr_reload)
			shift_q <= LFSR_SEED;
		else if (lfsr_step)
			shift_q <= {shift_q[LFSR_W-2:0], feedback_in};	// Shift up, new bit 0
	end

	assign lfsr_state = shift_q;

endmodule

// File: design/frame_step_decode.sv
module frame_step_decode (
	input  frame_timer_pkg::lfsr_t      lfsr_state,
	input  logic                        mode_5step,
	output frame_timer_pkg::step_hits_t step_hits
);

	import frame_timer_pkg::*;

	logic match_step1;
	logic match_step2;
	logic match_step3;
	logic match_step4;
	logic match_step5;

	// Full 15-bit compares against the precomputed states
	assign match_step1 = (lfsr_state == STEP1_PATTERN);
	assign match_step2 = (lfsr_state == STEP2_PATTERN);
	assign match_step3 = (lfsr_state == STEP3_PATTERN);
	assign match_step4 = (lfsr_state == STEP4_PATTERN);
	assign match_step5 = (lfsr_state == STEP5_PATTERN);

	assign step_hits[0] = match_step1;
	assign step_hits[1] = match_step2;
	assign step_hits[2] = match_step3;
	assign step_hits[3] = match_step4 & ~mode_5step;	// Passes unmatched in 5-step
	assign step_hits[4] = match_step5;

endmodule

// File: design/frame_irq_status.sv
module frame_irq_status (
	input  logic phi1,
	input  logic reset,
	input  logic frame_irq_set,
	input  logic irq_inhibit,
	input  logic read_status,
	input  logic dmc_irq,
	output logic irq,
	output logic status_frame_irq
);

	logic frame_flag;

	// Set beats a same-cycle read, inhibit keeps it clear
	always_ff @(posedge phi1) begin
		if (reset)
			frame_flag <= 1'b0;
		else if (frame_irq_set && !irq_inhibit)
			frame_flag <= 1'b1;
		else if (read_status || irq_inhibit)
			frame_flag <= 1'b0;
	end

	assign status_frame_irq = frame_flag;
	assign irq              = frame_flag | dmc_irq;	// Shared interrupt line

endmodule

// File: design/frame_counter.sv
module frame_counter (
	input  logic                    phi1,
	input  logic                    reset,
	input  apu_regs_pkg::reg_data_t reg_data,
	input  logic                    write_frame,
	input  logic                    read_status,
	input  logic                    dmc_irq,
	output logic                    quarter_frame,
	output logic                    half_frame,
	output logic                    irq,
	output logic                    status_frame_irq
);

	import frame_timer_pkg::*;

	lfsr_t      lfsr_state;
	step_hits_t step_hits;
	logic       lfsr_reload;
	logic       lfsr_step;
	logic       feedback_in;
	logic       mode_5step;
	logic       irq_inhibit;
	logic       frame_irq_set;

	frame_sequencer_ctrl i_ctrl (
		.phi1          (phi1),
		.reset         (reset),
		.reg_data      (reg_data),
		.write_frame   (write_frame),
		.step_hits     (step_hits),
		.lfsr_state    (lfsr_state),
		.lfsr_reload   (lfsr_reload),
		.lfsr_step     (lfsr_step),
		.feedback_in   (feedback_in),
		.mode_5step    (mode_5step),
		.irq_inhibit   (irq_inhibit),
		.frame_irq_set (frame_irq_set),
		.quarter_frame (quarter_frame),
		.half_frame    (half_frame)
	);

	frame_lfsr i_lfsr (
		.phi1        (phi1),
		.reset       (reset),
		.lfsr_reload (lfsr_reload),
		.lfsr_step   (lfsr_step),
		.feedback_in (feedback_in),
		.lfsr_state  (lfsr_state)
	);

	frame_step_decode i_decode (
		.lfsr_state (lfsr_state),
		.mode_5step (mode_5step),
		.step_hits  (step_hits)
	);

	frame_irq_status i_irq (
		.phi1             (phi1),
		.reset            (reset),
		.frame_irq_set    (frame_irq_set),
		.irq_inhibit      (irq_inhibit),
		.read_status      (read_status),
		.dmc_irq          (dmc_irq),
		.irq              (irq),
		.status_frame_irq (status_frame_irq)
	);

endmodule

// File: tb/frame_counter_props.sv
module frame_counter_props (
	input  logic                    phi1,
	input  logic                    reset,
	input  apu_regs_pkg::reg_data_t reg_data,
	input  logic                    write_frame,
	input  logic                    read_status,
	input  logic                    dmc_irq,
	input  logic                    quarter_frame,
	input  logic                    half_frame,
	input  logic                    irq,
	input  logic                    status_frame_irq,
	output int                      check_errors
);

	timeunit 1ns;
	timeprecision 1ps;

	import apu_regs_pkg::*;
	import frame_timer_pkg::*;

	// Cycles from a reload strobe to the step 1 pulse
	localparam int unsigned FIRST_GAP = 2 * (STEP1_COUNT + 1);

	logic        mode5;
	logic        inhibit;
	logic        exp_flag;
	int          q_next;	// Step of the next quarter pulse, 0 is the write pulse
	int          q_last;
	int unsigned q_gap;
	logic        q_synced;
	int          h_last;
	int unsigned h_gap;
	logic        h_synced;
	int unsigned first_lo;
	int unsigned first_hi;

	function automatic int unsigned step_count_of(input int step);
		case (step)
			1:       return STEP1_COUNT;
			2:       return STEP2_COUNT;
			3:       return STEP3_COUNT;
			4:       return STEP4_COUNT;
			5:       return STEP5_COUNT;
			default: return 0;
		endcase
	endfunction

	// Steps whose strobe reloads the counter
	function automatic logic ends_frame(input int step, input logic five);
		return (step == 0) || (step == (five ? 5 : 4));
	endfunction

	function automatic logic is_half_step(input int step, input logic five);
		return (step == 2) || ends_frame(step, five);
	endfunction

	function automatic int following_step(input int step, input logic five);
		case (step)
			0:       return 1;
			1:       return 2;
			2:       return 3;
			3:       return five ? 5 : 4;
			default: return 1;
		endcase
	endfunction

	// Two phi1 cycles per aclk strobe
	function automatic int unsigned pulse_gap(input int from_step, input int to_step,
		input logic five);
		if (ends_frame(from_step, five))
			return 2 * (step_count_of(to_step) + 1);
		return 2 * (step_count_of(to_step) - step_count_of(from_step));
	endfunction

	always @(posedge phi1) begin
		if (reset) begin
			check_errors = 0;
			mode5    <= 1'b0;
			inhibit  <= 1'b0;
			exp_flag <= 1'b0;
			q_next   <= 1;
			q_last   <= 0;
			q_synced <= 1'b0;
			q_gap    <= 0;
			h_last   <= 0;
			h_synced <= 1'b0;
			h_gap    <= 0;
		end else begin
			assert (irq == (exp_flag | dmc_irq)) else begin
				$display("ERROR irq: got %h, expected %h", irq, exp_flag | dmc_irq);
				check_errors++;
			end
			assert (status_frame_irq == exp_flag) else begin
				$display("ERROR status_frame_irq: got %h, expected %h",
					status_frame_irq, exp_flag);
				check_errors++;
			end
			if (quarter_frame) begin
				first_lo = (q_next == 0) ? 1 : FIRST_GAP;
				first_hi = first_lo + 4;
				if (q_synced) begin
					assert (q_gap + 1 == pulse_gap(q_last, q_next, mode5)) else begin
						$display("ERROR quarter_frame gap: got %h, expected %h",
							q_gap + 1, pulse_gap(q_last, q_next, mode5));
						check_errors++;
					end
				end else begin
					assert (q_gap + 1 >= first_lo && q_gap + 1 <= first_hi) else begin
						$display("ERROR quarter_frame first delay: got %h, expected %h to %h",
							q_gap + 1, first_lo, first_hi);
						check_errors++;
					end
				end
				assert (half_frame == is_half_step(q_next, mode5)) else begin
					$display("ERROR half_frame at step %0d: got %h, expected %h",
						q_next, half_frame, is_half_step(q_next, mode5));
					check_errors++;
				end
				q_last   <= q_next;
				q_next   <= following_step(q_next, mode5);
				q_synced <= 1'b1;
				q_gap    <= 0;
			end else begin
				assert (!half_frame) else begin
					$display("ERROR half_frame without quarter_frame: got %h, expected %h",
						half_frame, 1'b0);
					check_errors++;
				end
				q_gap <= q_gap + 1;
			end
			if (half_frame) begin
				if (h_synced) begin
					assert (h_gap + 1 == pulse_gap(h_last, q_next, mode5)) else begin
						$display("ERROR half_frame gap: got %h, expected %h",
							h_gap + 1, pulse_gap(h_last, q_next, mode5));
						check_errors++;
					end
				end
				h_last   <= q_next;
				h_synced <= 1'b1;
				h_gap    <= 0;
			end else begin
				h_gap <= h_gap + 1;
			end
			if (quarter_frame && q_next == 4 && !inhibit)
				exp_flag <= 1'b1;	// Step 4 of a 4-step frame
			else if (read_status || inhibit)
				exp_flag <= 1'b0;
			if (write_frame) begin
				mode5    <= reg_data[FRAME_MODE_BIT];
				inhibit  <= reg_data[FRAME_INHIBIT_BIT];
				q_next   <= reg_data[FRAME_MODE_BIT] ? 0 : 1;
				q_synced <= 1'b0;
				q_gap    <= 0;
				h_synced <= 1'b0;
			end
		end
	end

endmodule

// File: tb/frame_counter_tb.sv
module frame_counter_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import apu_regs_pkg::*;

	localparam int TIMEOUT_CYCLES = 50000;
	localparam int EV_QUARTER     = 0;
	localparam int EV_HALF        = 1;
	localparam int EV_FLAG_HIGH   = 2;
	localparam int EV_FLAG_LOW    = 3;

	logic      phi1;
	logic      reset;
	reg_data_t reg_data;
	logic      write_frame;
	logic      read_status;
	logic      dmc_irq;
	logic      quarter_frame;
	logic      half_frame;
	logic      irq;
	logic      status_frame_irq;

	int check_errors;
	int timeouts;
	int errors_at_start;
	int test_count;
	int failed_tests;
	int seed;

	frame_counter i_dut (
		.phi1             (phi1),
		.reset            (reset),
		.reg_data         (reg_data),
		.write_frame      (write_frame),
		.read_status      (read_status),
		.dmc_irq          (dmc_irq),
		.quarter_frame    (quarter_frame),
		.half_frame       (half_frame),
		.irq              (irq),
		.status_frame_irq (status_frame_irq)
	);

	frame_counter_props i_props (
		.phi1             (phi1),
		.reset            (reset),
		.reg_data         (reg_data),
		.write_frame      (write_frame),
		.read_status      (read_status),
		.dmc_irq          (dmc_irq),
		.quarter_frame    (quarter_frame),
		.half_frame       (half_frame),
		.irq              (irq),
		.status_frame_irq (status_frame_irq),
		.check_errors     (check_errors)
	);

	initial begin
		phi1 = 1'b0;
		forever #50 phi1 = ~phi1;
	end

	function automatic logic event_seen(input int kind);
		case (kind)
			EV_QUARTER:   return quarter_frame;
			EV_HALF:      return half_frame;
			EV_FLAG_HIGH: return status_frame_irq;
			default:      return !status_frame_irq;
		endcase
	endfunction

	// Timeout restarts after each matching sample
	task automatic wait_for_event(input int kind, input int count, input string what);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		while (seen < count && cycles < TIMEOUT_CYCLES) begin
			@(negedge phi1);
			cycles++;
			if (event_seen(kind)) begin
				seen++;
				cycles = 0;
			end
		end
		if (seen < count) begin
			$display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
			timeouts++;
		end
	endtask

	task automatic write_frame_reg(input logic five_step, input logic inhibit);
		reg_data_t data;
		data = '0;
		data[FRAME_MODE_BIT] = five_step;
		data[FRAME_INHIBIT_BIT] = inhibit;
		@(negedge phi1);
		reg_data = data;
		write_frame = 1'b1;
		@(negedge phi1);
		write_frame = 1'b0;
	endtask

	task automatic pulse_read_status();
		@(negedge phi1);
		read_status = 1'b1;
		@(negedge phi1);
		read_status = 1'b0;
	endtask

	// New random dmc_irq level every cycle
	task automatic toggle_dmc(input int cycles, input logic until_flag);
		int n;
		int rnd;
		n = 0;
		while (n < cycles && !(until_flag && status_frame_irq)) begin
			@(negedge phi1);
			rnd = $random(seed);
			dmc_irq = rnd[0];
			n++;
		end
		if (until_flag && !status_frame_irq) begin
			$display("Timed out after %0d cycles waiting for the frame interrupt", cycles);
			timeouts++;
		end
	endtask

	task automatic start_test();
		errors_at_start = check_errors + timeouts;
	endtask

	task automatic end_test(input string name);
		int errors;
		errors = check_errors + timeouts - errors_at_start;
		test_count++;
		if (errors == 0) begin
			$display("Test %0d %s: ok", test_count, name);
		end else begin
			$display("Test %0d %s: %0d errors", test_count, name, errors);
			failed_tests++;
		end
	endtask

	initial begin
		seed = 32'hca9a;
		reset = 1'b1;
		reg_data = '0;
		write_frame = 1'b0;
		read_status = 1'b0;
		dmc_irq = 1'b0;
		timeouts = 0;
		errors_at_start = 0;
		test_count = 0;
		failed_tests = 0;
		repeat (10) @(negedge phi1);
		reset = 1'b0;

		start_test();
		wait_for_event(EV_QUARTER, 6, "quarter_frame pulses");
		end_test("quarter spacing after reset");

		start_test();
		wait_for_event(EV_HALF, 4, "half_frame pulses");
		end_test("half spacing in 4-step mode");

		start_test();
		pulse_read_status();
		wait_for_event(EV_FLAG_LOW, 1, "the flag to clear");
		wait_for_event(EV_FLAG_HIGH, 1, "the frame interrupt");
		pulse_read_status();
		wait_for_event(EV_FLAG_LOW, 1, "the flag to clear after a read");
		end_test("frame interrupt and status read");

		start_test();
		wait_for_event(EV_FLAG_HIGH, 1, "the frame interrupt");
		write_frame_reg(1'b0, 1'b1);
		wait_for_event(EV_FLAG_LOW, 1, "inhibit to clear the flag");
		wait_for_event(EV_QUARTER, 5, "a full inhibited frame");
		end_test("interrupt inhibit");

		start_test();
		write_frame_reg(1'b1, 1'b0);
		wait_for_event(EV_QUARTER, 6, "5-step quarter pulses");
		end_test("5-step sequence");

		start_test();
		write_frame_reg(1'b0, 1'b0);
		toggle_dmc(TIMEOUT_CYCLES, 1'b1);
		pulse_read_status();
		toggle_dmc(200, 1'b0);
		dmc_irq = 1'b0;
		end_test("irq merge with random dmc_irq");

		$display("Tests run: %0d, failed: %0d, check errors: %0d, timeouts: %0d",
			test_count, failed_tests, check_errors, timeouts);
		if (failed_tests == 0 && check_errors == 0 && timeouts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: frame_counter.f
design/apu_regs_pkg.sv
design/frame_timer_pkg.sv
design/frame_sequencer_ctrl.sv
design/frame_lfsr.sv
design/frame_step_decode.sv
design/frame_irq_status.sv
design/frame_counter.sv
tb/frame_counter_props.sv
tb/frame_counter_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the frame counter testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module frame_counter_tb -Mdir obj_dir -o frame_counter_sim \
	-f frame_counter.f

./obj_dir/frame_counter_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
